// File: filelist.f
hdl/rdma_field_pkg.sv
hdl/rdma_opcode_pkg.sv
hdl/req_seg_ctrl.sv
hdl/seg_addr_unit.sv
hdl/seg_opcode_sel.sv
hdl/req_out_queue.sv
hdl/rdma_req_segmenter.sv
sim/rdma_req_segmenter_properties.sv
sim/tb_rdma_req_segmenter.sv

// File: sim/tb_rdma_req_segmenter.sv
// Testbench of the RDMA request segmenter
// Applies a table of work requests and checks every command against a
// reference model of the segmentation rules, with and without output stalls

`timescale 1ns/1ns
`default_nettype none

module tb_rdma_req_segmenter;

  localparam int PMTU_BYTES     = 1024;
  localparam int MAX_READ_BYTES = 4096;
  localparam int QUEUE_DEPTH    = 8;
  localparam int NUM_REQ        = 14;
  localparam int STALL_FROM     = 9;     // First entry run with m_ready stalls
  localparam int TIMEOUT_CYCLES = 2000;
  localparam logic PARSE = rdma_opcode_pkg::RDMA_MODE_PARSE;
  localparam logic RAW   = rdma_opcode_pkg::RDMA_MODE_RAW;

  typedef struct packed {
    rdma_field_pkg::qpn_t    qpn;
    logic                    mode;
    rdma_field_pkg::opcode_t opcode;
    logic                    last;
    rdma_field_pkg::vaddr_t  lvaddr;
    rdma_field_pkg::vaddr_t  rvaddr;
    rdma_field_pkg::len_t    len;
    int                      n_chunks;
  } req_t;

  typedef struct packed {
    rdma_field_pkg::qpn_t    qpn;
    rdma_field_pkg::opcode_t op;
    logic                    last;
    rdma_field_pkg::vaddr_t  lv;
    rdma_field_pkg::vaddr_t  rv;
    rdma_field_pkg::len_t    len;
  } cmd_t;

  logic                    aclk, aresetn;
  logic                    s_valid, s_ready, s_mode, s_last;
  rdma_field_pkg::qpn_t    s_qpn, m_qpn;
  rdma_field_pkg::opcode_t s_opcode, m_opcode;
  rdma_field_pkg::vaddr_t  s_lvaddr, s_rvaddr, m_lvaddr, m_rvaddr;
  rdma_field_pkg::len_t    s_len, m_len;
  logic                    m_valid, m_ready, m_last;

  req_t   tbl [NUM_REQ];
  cmd_t   exp_q [$];             // Commands still owed by the DUT
  cmd_t   got, exp_cmd;
  integer seed = 32'ha45a;
  logic   stall_mode = 1'b0;
  int     mismatches = 0;
  int     failures = 0;
  int     received = 0;
  int     total = 0;
  logic   ok;

  rdma_req_segmenter #(
    .PMTU_BYTES (PMTU_BYTES), .MAX_READ_BYTES (MAX_READ_BYTES), .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_rdma_req_segmenter (
    .aclk, .aresetn, .s_valid, .s_ready, .s_qpn, .s_mode, .s_opcode, .s_last,
    .s_lvaddr, .s_rvaddr, .s_len, .m_valid, .m_ready, .m_qpn, .m_opcode, .m_last,
    .m_lvaddr, .m_rvaddr, .m_len
  );

  always #20 aclk = ~aclk;

  // Output back-pressure with one ready cycle in four while stalling
  always @(posedge aclk) begin
    #2;
    m_ready = stall_mode ? (($random(seed) & 3) == 0) : 1'b1;
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  function automatic rdma_field_pkg::opcode_t wire_opcode(input logic is_read,
      input logic is_send, input logic first, input logic fin);
    if (is_read) return rdma_opcode_pkg::RC_RDMA_READ_REQUEST;
    if (is_send) begin
      if (first) return fin ? rdma_opcode_pkg::RC_SEND_ONLY : rdma_opcode_pkg::RC_SEND_FIRST;
      return fin ? rdma_opcode_pkg::RC_SEND_LAST : rdma_opcode_pkg::RC_SEND_MIDDLE;
    end
    if (first) begin
      return fin ? rdma_opcode_pkg::RC_RDMA_WRITE_ONLY : rdma_opcode_pkg::RC_RDMA_WRITE_FIRST;
    end
    return fin ? rdma_opcode_pkg::RC_RDMA_WRITE_LAST : rdma_opcode_pkg::RC_RDMA_WRITE_MIDDLE;
  endfunction

  task automatic add_expected(input req_t r, input int idx);
    cmd_t                   c;
    rdma_field_pkg::len_t   rem, size;
    rdma_field_pkg::vaddr_t lv, rv;
    logic                   is_read, is_send, first, fin;
    int                     n;
    n = 0;
    c.qpn = r.qpn;
    if (r.mode == RAW && r.opcode != rdma_opcode_pkg::RC_RDMA_READ_REQUEST) begin
      c.op   = r.opcode;     // Pass-through
      c.last = r.last && (r.opcode inside {rdma_opcode_pkg::RC_RDMA_WRITE_LAST,
        rdma_opcode_pkg::RC_RDMA_WRITE_ONLY, rdma_opcode_pkg::RC_SEND_LAST,
        rdma_opcode_pkg::RC_SEND_ONLY});
      c.lv   = r.lvaddr;
      c.rv   = r.rvaddr;
      c.len  = r.len;
      exp_q.push_back(c);
      n = 1;
    end else if (r.mode == RAW || (r.opcode >= rdma_opcode_pkg::APP_READ &&
                                   r.opcode <= rdma_opcode_pkg::APP_IMMED)) begin
      is_read = (r.mode == RAW) || (r.opcode == rdma_opcode_pkg::APP_READ);
      is_send = !is_read && (r.opcode != rdma_opcode_pkg::APP_WRITE);
      size    = is_read ? MAX_READ_BYTES : PMTU_BYTES;
      rem     = r.len;
      lv      = r.lvaddr;
      rv      = is_send ? '0 : r.rvaddr;
      first   = 1'b1;
      do begin
        fin    = (rem <= size);
        c.op   = wire_opcode(is_read, is_send, first, fin);
        c.last = fin && r.last;  // Only the closing chunk
        c.lv   = lv;
        c.rv   = rv;
        c.len  = fin ? rem : size;
        exp_q.push_back(c);
        n++;
        lv    = lv + size;
        rv    = is_send ? rv : rv + size;
        rem   = fin ? '0 : rem - size;
        first = 1'b0;
      end while (!fin);
    end
    assert (n == r.n_chunks) else begin
      failures++;
      $display("Request %0d: model gives %0d commands, table expects %0d", idx, n, r.n_chunks);
    end
  endtask

  function automatic req_t make_req(input logic mode, input rdma_field_pkg::opcode_t op,
      input logic last, input int qpn, input rdma_field_pkg::vaddr_t lv,
      input rdma_field_pkg::vaddr_t rv, input rdma_field_pkg::len_t len, input int n);
    req_t r;
    r.qpn      = rdma_field_pkg::qpn_t'(qpn);
    r.mode     = mode;
    r.opcode   = op;
    r.last     = last;
    r.lvaddr   = lv;
    r.rvaddr   = rv;
    r.len      = len;
    r.n_chunks = n;
    return r;
  endfunction

  ////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////
  // Sampled mid-cycle ahead of the transfer edge
  always @(negedge aclk) begin
    if (aresetn && m_valid && m_ready) begin
      got = '{m_qpn, m_opcode, m_last, m_lvaddr, m_rvaddr, m_len};
      received++;
      assert (exp_q.size() != 0) else begin
        failures++;
        $display("Command at %0t ns arrived with none expected", $time);
      end
      if (exp_q.size() != 0) begin
        exp_cmd = exp_q.pop_front();
        assert (got == exp_cmd) else begin
          mismatches++;
          $display("MISMATCH at %0t ns: cmd %0d got qpn %0d op %0d last %0b lv %h rv %h len %0d",
                   $time, received, got.qpn, got.op, got.last, got.lv, got.rv, got.len);
          $display("  expected qpn %0d op %0d last %0b lv %h rv %h len %0d",
                   exp_cmd.qpn, exp_cmd.op, exp_cmd.last, exp_cmd.lv, exp_cmd.rv, exp_cmd.len);
        end
      end
    end
  end

  task automatic send_request(input int idx, output logic accepted);
    int cnt;
    add_expected(tbl[idx], idx);
    s_qpn    = tbl[idx].qpn;
    s_mode   = tbl[idx].mode;
    s_opcode = tbl[idx].opcode;
    s_last   = tbl[idx].last;
    s_lvaddr = tbl[idx].lvaddr;
    s_rvaddr = tbl[idx].rvaddr;
    s_len    = tbl[idx].len;
    s_valid  = 1'b1;
    cnt = 0;
    while (!s_ready && cnt < TIMEOUT_CYCLES) begin
      @(posedge aclk);
      #2;
      cnt++;
    end
    accepted = s_ready;
    assert (accepted) else begin
      failures++;
      $display("Timeout: request %0d was never accepted", idx);
    end
    if (accepted) begin
      @(posedge aclk);  // Transfer edge
      #2;
      s_valid = 1'b0;
    end
  endtask

  initial begin
    int cnt;
    aclk = 1'b0;
    aresetn = 1'b0;
    s_valid = 1'b0;
    s_qpn = '0;
    s_mode = PARSE;
    s_opcode = '0;
    s_last = 1'b0;
    s_lvaddr = '0;
    s_rvaddr = '0;
    s_len = '0;
    m_ready = 1'b0;
    tbl[0]  = make_req(PARSE, rdma_opcode_pkg::APP_WRITE, 1, 1, 'h10000, 'h80000, 2560, 3);
    tbl[1]  = make_req(PARSE, rdma_opcode_pkg::APP_SEND, 1, 2, 'h20000, 'hdead0000, 1024, 1);
    tbl[2]  = make_req(PARSE, rdma_opcode_pkg::APP_IMMED, 1, 3, 'h30000, 'h1234, 0, 1);
    tbl[3]  = make_req(PARSE, rdma_opcode_pkg::APP_READ, 1, 4, 'h40000, 'h90000, 10000, 3);
    tbl[4]  = make_req(RAW, rdma_opcode_pkg::RC_RDMA_READ_REQUEST, 0, 5, 'h50000, 'ha0000,
                       9000, 3);
    tbl[5]  = make_req(RAW, rdma_opcode_pkg::RC_RDMA_WRITE_MIDDLE, 1, 6, 'h60000, 'hb0000,
                       1024, 1);
    tbl[6]  = make_req(RAW, rdma_opcode_pkg::RC_SEND_LAST, 1, 7, 'h70000, 'hc0000, 300, 1);
    tbl[7]  = make_req(PARSE, 9, 1, 8, 'h0, 'h0, 4096, 0);  // Unknown opcode is dropped
    tbl[8]  = make_req(PARSE, rdma_opcode_pkg::APP_WRITE, 0, 9, 'h80000, 'hd0000, 1024, 1);
    tbl[9]  = make_req(PARSE, rdma_opcode_pkg::APP_WRITE, 1, 10, 'h100000000, 'h200000000,
                       8192, 8);
    tbl[10] = make_req(PARSE, rdma_opcode_pkg::APP_SEND, 1, 11, 'h5000, 'h6000, 5000, 5);
    tbl[11] = make_req(PARSE, rdma_opcode_pkg::APP_READ, 1, 12, 'h7000, 'h8000, 8192, 2);
    tbl[12] = make_req(RAW, rdma_opcode_pkg::RC_RDMA_WRITE_ONLY, 1, 13, 'h9000, 'ha000, 700, 1);
    tbl[13] = make_req(PARSE, rdma_opcode_pkg::APP_IMMED, 0, 14, 'hb000, 'hc000, 3000, 3);

    repeat (8) @(posedge aclk);
    #2;
    aresetn = 1'b1;

    ok = 1'b1;
    for (int i = 0; i < NUM_REQ && ok; i++) begin
      if (i == STALL_FROM) begin
        @(negedge aclk);
        stall_mode = 1'b1;
        @(posedge aclk);
        #2;
      end
      total += tbl[i].n_chunks;
      send_request(i, ok);
    end

    // Drain the queue
    cnt = 0;
    while (ok && exp_q.size() != 0 && cnt < TIMEOUT_CYCLES) begin
      @(posedge aclk);
      cnt++;
    end
    if (ok) begin
      assert (exp_q.size() == 0) else begin
        failures++;
        $display("Timeout: %0d commands never came out", exp_q.size());
      end
      repeat (20) @(posedge aclk);  // Quiet window for stray commands
      #2;
      assert (received == total && s_ready) else begin
        failures++;
        $display("Received %0d commands of %0d, or the unit did not return to idle",
                 received, total);
      end
    end

    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/rdma_req_segmenter_properties.sv
// Handshake properties of the RDMA request segmenter
// Bound to the top level to check both valid/ready ports and the busy window

`timescale 1ns/1ns
`default_nettype none

module rdma_req_segmenter_properties (
  input wire                          aclk,
  input wire                          aresetn,
  input wire                          s_valid,
  input wire                          s_ready,
  input wire rdma_field_pkg::qpn_t    s_qpn,
  input wire                          s_mode,
  input wire rdma_field_pkg::opcode_t s_opcode,
  input wire                          s_last,
  input wire rdma_field_pkg::vaddr_t  s_lvaddr,
  input wire rdma_field_pkg::vaddr_t  s_rvaddr,
  input wire rdma_field_pkg::len_t    s_len,
  input wire                          m_valid,
  input wire                          m_ready,
  input wire rdma_field_pkg::qpn_t    m_qpn,
  input wire rdma_field_pkg::opcode_t m_opcode,
  input wire                          m_last,
  input wire rdma_field_pkg::vaddr_t  m_lvaddr,
  input wire rdma_field_pkg::vaddr_t  m_rvaddr,
  input wire rdma_field_pkg::len_t    m_len,
  input wire                          load,
  input wire                          q_push,
  input wire                          q_ready,
  input wire                          final_chunk
);

  logic req_open;  // Accepted request with commands still to queue

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      req_open <= 1'b0;
    end else if (load) begin
      req_open <= 1'b1;
    end else if (q_push && q_ready && final_chunk) begin
      req_open <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Valid holds with stable data
  ////////////////////////////////////////
  a_s_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    s_valid && !s_ready |=> s_valid &&
      $stable({s_qpn, s_mode, s_opcode, s_last, s_lvaddr, s_rvaddr, s_len}))
    else $error("Request dropped or changed before it was accepted");

  a_m_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    m_valid && !m_ready |=> m_valid &&
      $stable({m_qpn, m_opcode, m_last, m_lvaddr, m_rvaddr, m_len}))
    else $error("Command dropped or changed before it was taken");

  // Output port quiet out of reset
  a_m_reset: assert property (@(posedge aclk) !aresetn |=> !m_valid)
    else $error("m_valid high after reset");

  // Input stays closed until the final command of a request is queued
  a_busy: assert property (@(posedge aclk) disable iff (!aresetn) req_open |-> !s_ready)
    else $error("Input reopened before the request was fully queued");

endmodule

bind rdma_req_segmenter rdma_req_segmenter_properties u_props (.*);

`default_nettype wire

// File: hdl/rdma_req_segmenter.sv
// RDMA request segmenter
// Cuts send queue work requests into RC wire commands and queues them
// on a valid/ready output

`timescale 1ns/1ns
`default_nettype none

module rdma_req_segmenter #(
  parameter int PMTU_BYTES     = 1024,
  parameter int MAX_READ_BYTES = 4096,
  parameter int QUEUE_DEPTH    = 8
) (
  input  wire                           aclk,
  input  wire                           aresetn,
  // Work requests
  input  wire                           s_valid,
  output logic                          s_ready,
  input  wire  rdma_field_pkg::qpn_t    s_qpn,
  input  wire                           s_mode,
  input  wire  rdma_field_pkg::opcode_t s_opcode,
  input  wire                           s_last,
  input  wire  rdma_field_pkg::vaddr_t  s_lvaddr,
  input  wire  rdma_field_pkg::vaddr_t  s_rvaddr,
  input  wire  rdma_field_pkg::len_t    s_len,
  // Wire commands
  output logic                          m_valid,
  input  wire                           m_ready,
  output rdma_field_pkg::qpn_t          m_qpn,
  output rdma_field_pkg::opcode_t       m_opcode,
  output logic                          m_last,
  output rdma_field_pkg::vaddr_t        m_lvaddr,
  output rdma_field_pkg::vaddr_t        m_rvaddr,
  output rdma_field_pkg::len_t          m_len
);

  logic                       load, step, q_push, q_ready, final_chunk, chunk_last;
  rdma_opcode_pkg::seg_kind_t kind;
  rdma_field_pkg::qpn_t       qpn_q;  // Same for every chunk of a request
  rdma_field_pkg::vaddr_t     chunk_lvaddr, chunk_rvaddr;
  rdma_field_pkg::len_t       chunk_len;
  rdma_field_pkg::opcode_t    chunk_opcode;

  always_ff @(posedge aclk) begin
    if (load) qpn_q <= s_qpn;
  end

  req_seg_ctrl #(.PMTU_BYTES(PMTU_BYTES), .MAX_READ_BYTES(MAX_READ_BYTES)) u_ctrl (
    .aclk, .aresetn, .s_valid, .s_ready, .s_mode, .s_opcode,
    .load, .step, .kind, .final_chunk, .q_push, .q_ready
  );

  seg_addr_unit #(.PMTU_BYTES(PMTU_BYTES), .MAX_READ_BYTES(MAX_READ_BYTES)) u_addr (
    .aclk, .aresetn, .load, .step, .kind,
    .lvaddr_in (s_lvaddr), .rvaddr_in (s_rvaddr), .len_in (s_len),
    .chunk_lvaddr, .chunk_rvaddr, .chunk_len, .final_chunk
  );

  seg_opcode_sel u_opsel (
    .aclk, .aresetn, .load, .step, .kind,
    .opcode_in (s_opcode), .last_in (s_last), .final_chunk, .chunk_opcode, .chunk_last
  );

  req_out_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
    .aclk, .aresetn,
    .push       (q_push),
    .push_ready (q_ready),
    .in_qpn     (qpn_q),
    .in_opcode  (chunk_opcode),
    .in_last    (chunk_last),
    .in_lvaddr  (chunk_lvaddr),
    .in_rvaddr  (chunk_rvaddr),
    .in_len     (chunk_len),
    .m_valid, .m_ready, .m_qpn, .m_opcode, .m_last, .m_lvaddr, .m_rvaddr, .m_len,
    .fill       ()  // Occupancy for monitoring
  );

endmodule

`default_nettype wire

// File: hdl/req_out_queue.sv
// Command output queue
// Register-array FIFO of finished commands with a registered output stage
// and a count of the stored commands

`timescale 1ns/1ns
`default_nettype none

module req_out_queue #(
  parameter int QUEUE_DEPTH = 8
) (
  input  wire                              aclk,
  input  wire                              aresetn,
  input  wire                              push,
  output logic                             push_ready,
  input  wire  rdma_field_pkg::qpn_t       in_qpn,
  input  wire  rdma_field_pkg::opcode_t    in_opcode,
  input  wire                              in_last,
  input  wire  rdma_field_pkg::vaddr_t     in_lvaddr,
  input  wire  rdma_field_pkg::vaddr_t     in_rvaddr,
  input  wire  rdma_field_pkg::len_t       in_len,
  output logic                             m_valid,
  input  wire                              m_ready,
  output rdma_field_pkg::qpn_t             m_qpn,
  output rdma_field_pkg::opcode_t          m_opcode,
  output logic                             m_last,
  output rdma_field_pkg::vaddr_t           m_lvaddr,
  output rdma_field_pkg::vaddr_t           m_rvaddr,
  output rdma_field_pkg::len_t             m_len,
  output logic [$clog2(QUEUE_DEPTH+2)-1:0] fill
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 2);

  logic [rdma_field_pkg::CMD_BITS-1:0] mem [QUEUE_DEPTH];
  logic [rdma_field_pkg::CMD_BITS-1:0] out_q;
  logic [PTR_W-1:0]                    wr_ptr, rd_ptr;
  logic [CNT_W-1:0]                    count;   // Entries in the array
  logic                                do_push, do_pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push_ready = (count < CNT_W'(QUEUE_DEPTH));
  assign do_push    = push && push_ready;
  assign do_pop     = (count != '0) && (!m_valid || m_ready);  // Refill output stage

  always_ff @(posedge aclk) begin
    if (do_push) begin
      mem[wr_ptr] <= {in_qpn, in_opcode, in_last, in_lvaddr, in_rvaddr, in_len};
    end
    if (do_pop) begin
      out_q <= mem[rd_ptr];
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      m_valid <= 1'b0;
    end else begin
      if (do_push) wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
      count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
      if (do_pop) begin
        m_valid <= 1'b1;
      end else if (m_ready) begin
        m_valid <= 1'b0;
      end
    end
  end

  assign {m_qpn, m_opcode, m_last, m_lvaddr, m_rvaddr, m_len} = out_q;
  assign fill = count + CNT_W'(m_valid);  // Output stage counts too

endmodule

`default_nettype wire

// File: hdl/seg_opcode_sel.sv
// Segment opcode selector
// Picks the wire opcode and last flag of each chunk from the segment kind,
// its position in the request and the request's own last flag

`timescale 1ns/1ns
`default_nettype none

module seg_opcode_sel (
  input  wire                               aclk,
  input  wire                               aresetn,
  input  wire                               load,
  input  wire                               step,
  input  wire  rdma_opcode_pkg::seg_kind_t  kind,
  input  wire  rdma_field_pkg::opcode_t     opcode_in,
  input  wire                               last_in,
  input  wire                               final_chunk,
  output rdma_field_pkg::opcode_t           chunk_opcode,
  output logic                              chunk_last
);

  logic                    first_q;        // Next chunk opens the request
  logic                    chunk_first_q;  // Chunk on the outputs opened it
  logic                    last_q;
  rdma_field_pkg::opcode_t op_q;           // Raw opcode
  logic                    raw_keeps_last;

  // Raw commands keep last only when they close a message
  assign raw_keeps_last = opcode_in inside {rdma_opcode_pkg::RC_RDMA_WRITE_LAST,
                                            rdma_opcode_pkg::RC_RDMA_WRITE_ONLY,
                                            rdma_opcode_pkg::RC_SEND_LAST,
                                            rdma_opcode_pkg::RC_SEND_ONLY};

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      first_q       <= 1'b0;
      chunk_first_q <= 1'b0;
    end else if (load) begin
      first_q <= 1'b1;
    end else if (step) begin
      chunk_first_q <= first_q;
      first_q       <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (load) begin
      op_q   <= opcode_in;
      last_q <= (kind == rdma_opcode_pkg::SEG_RAW) ? (last_in && raw_keeps_last) : last_in;
    end
  end

  ////////////////////////////////////////
  // Opcode of the current chunk
  ////////////////////////////////////////
  always_comb begin
    case (kind)
      rdma_opcode_pkg::SEG_READ: chunk_opcode = rdma_opcode_pkg::RC_RDMA_READ_REQUEST;
      rdma_opcode_pkg::SEG_WRITE: begin
        if (chunk_first_q) begin
          chunk_opcode = final_chunk ? rdma_opcode_pkg::RC_RDMA_WRITE_ONLY
                                     : rdma_opcode_pkg::RC_RDMA_WRITE_FIRST;
        end else begin
          chunk_opcode = final_chunk ? rdma_opcode_pkg::RC_RDMA_WRITE_LAST
                                     : rdma_opcode_pkg::RC_RDMA_WRITE_MIDDLE;
        end
      end
      rdma_opcode_pkg::SEG_SEND: begin
        if (chunk_first_q) begin
          chunk_opcode = final_chunk ? rdma_opcode_pkg::RC_SEND_ONLY
                                     : rdma_opcode_pkg::RC_SEND_FIRST;
        end else begin
          chunk_opcode = final_chunk ? rdma_opcode_pkg::RC_SEND_LAST
                                     : rdma_opcode_pkg::RC_SEND_MIDDLE;
        end
      end
      default: chunk_opcode = op_q;  // Raw pass-through
    endcase
  end

  assign chunk_last = final_chunk && last_q;  // Final is always set for raw

endmodule

`default_nettype wire

// File: hdl/seg_addr_unit.sv
// Segment address unit
// Holds the remaining addresses and length of a request and emits one
// chunk per step, sized by the read limit or the PMTU

`timescale 1ns/1ns
`default_nettype none

module seg_addr_unit #(
  parameter int PMTU_BYTES     = 1024,
  parameter int MAX_READ_BYTES = 4096
) (
  input  wire                               aclk,
  input  wire                               aresetn,
  input  wire                               load,
  input  wire                               step,
  input  wire  rdma_opcode_pkg::seg_kind_t  kind,
  input  wire  rdma_field_pkg::vaddr_t      lvaddr_in,
  input  wire  rdma_field_pkg::vaddr_t      rvaddr_in,
  input  wire  rdma_field_pkg::len_t        len_in,
  output rdma_field_pkg::vaddr_t            chunk_lvaddr,
  output rdma_field_pkg::vaddr_t            chunk_rvaddr,
  output rdma_field_pkg::len_t              chunk_len,
  output logic                              final_chunk
);

  localparam rdma_field_pkg::len_t PMTU_LEN = rdma_field_pkg::len_t'(PMTU_BYTES);
  localparam rdma_field_pkg::len_t READ_LEN = rdma_field_pkg::len_t'(MAX_READ_BYTES);

  rdma_field_pkg::vaddr_t rem_lvaddr;
  rdma_field_pkg::vaddr_t rem_rvaddr;
  rdma_field_pkg::len_t   rem_len;
  rdma_field_pkg::len_t   chunk_size;
  logic                   fits;        // Remainder fits in one chunk
  logic                   is_send;

  assign is_send    = (kind == rdma_opcode_pkg::SEG_SEND);
  assign chunk_size = (kind == rdma_opcode_pkg::SEG_READ) ? READ_LEN : PMTU_LEN;
  assign fits       = (rem_len <= chunk_size);

  ////////////////////////////////////////
  // Remaining request
  ////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (load) begin
      rem_lvaddr <= lvaddr_in;
      rem_rvaddr <= rvaddr_in;
      rem_len    <= len_in;
    end else if (step) begin
      rem_lvaddr <= rem_lvaddr + rdma_field_pkg::vaddr_t'(chunk_size);
      if (!is_send) begin
        rem_rvaddr <= rem_rvaddr + rdma_field_pkg::vaddr_t'(chunk_size);
      end
      rem_len <= fits ? '0 : rem_len - chunk_size;
    end
  end

  ////////////////////////////////////////
  // Chunk outputs
  ////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (load && kind == rdma_opcode_pkg::SEG_RAW) begin
      chunk_lvaddr <= lvaddr_in;  // Pass-through, no parse cycle follows
      chunk_rvaddr <= rvaddr_in;
      chunk_len    <= len_in;
    end else if (step) begin
      chunk_lvaddr <= rem_lvaddr;
      chunk_rvaddr <= is_send ? '0 : rem_rvaddr;  // Sends carry no remote address
      chunk_len    <= fits ? rem_len : chunk_size;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      final_chunk <= 1'b0;
    end else if (load) begin
      final_chunk <= (kind == rdma_opcode_pkg::SEG_RAW);
    end else if (step) begin
      final_chunk <= fits;
    end
  end

endmodule

`default_nettype wire

// File: hdl/req_seg_ctrl.sv
// Segmenter control FSM
// Accepts one request at a time, classifies it into a segment kind and
// alternates parse and send cycles until the final chunk is queued

`timescale 1ns/1ns
`default_nettype none

module req_seg_ctrl #(
  parameter int PMTU_BYTES     = 1024,
  parameter int MAX_READ_BYTES = 4096
) (
  input  wire                               aclk,
  input  wire                               aresetn,
  input  wire                               s_valid,
  output logic                              s_ready,
  input  wire                               s_mode,
  input  wire  rdma_field_pkg::opcode_t     s_opcode,
  output logic                              load,
  output logic                              step,
  output rdma_opcode_pkg::seg_kind_t        kind,
  input  wire                               final_chunk,
  output logic                              q_push,
  input  wire                               q_ready
);

  // A zero chunk size would never finish a request
  if (PMTU_BYTES <= 0 || MAX_READ_BYTES <= 0) begin : g_bad_size
    $error("Chunk sizes must be positive");
  end

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PARSE,
    ST_SEND,
    ST_RAW_SEND
  } state_t;

  state_t                     state, state_nxt;
  rdma_opcode_pkg::seg_kind_t kind_req;  // Kind of the offered request
  rdma_opcode_pkg::seg_kind_t kind_q;    // Kind of the request in flight
  logic                       keep_req;  // Low for unknown opcodes
  logic                       accept;

  ////////////////////////////////////////
  // Request classification
  ////////////////////////////////////////
  always_comb begin
    kind_req = rdma_opcode_pkg::SEG_RAW;
    keep_req = 1'b1;
    if (s_mode == rdma_opcode_pkg::RDMA_MODE_RAW) begin
      // Raw reads still need cutting at the read limit
      if (s_opcode == rdma_opcode_pkg::RC_RDMA_READ_REQUEST) begin
        kind_req = rdma_opcode_pkg::SEG_READ;
      end
    end else begin
      case (s_opcode)
        rdma_opcode_pkg::APP_READ:  kind_req = rdma_opcode_pkg::SEG_READ;
        rdma_opcode_pkg::APP_WRITE: kind_req = rdma_opcode_pkg::SEG_WRITE;
        rdma_opcode_pkg::APP_SEND,
        rdma_opcode_pkg::APP_IMMED: kind_req = rdma_opcode_pkg::SEG_SEND;
        default:                    keep_req = 1'b0;  // Consumed and dropped
      endcase
    end
  end

  assign accept = (state == ST_IDLE) && s_valid;

  ////////////////////////////////////////
  // State machine
  ////////////////////////////////////////
  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (s_valid && keep_req) begin
          state_nxt = (kind_req == rdma_opcode_pkg::SEG_RAW) ? ST_RAW_SEND : ST_PARSE;
        end
      end
      ST_PARSE: state_nxt = ST_SEND;
      ST_SEND: begin
        if (q_ready) begin
          state_nxt = final_chunk ? ST_IDLE : ST_PARSE;
        end
      end
      ST_RAW_SEND: begin
        if (q_ready) begin
          state_nxt = ST_IDLE;
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state  <= ST_IDLE;
      kind_q <= rdma_opcode_pkg::SEG_READ;
    end else begin
      state <= state_nxt;
      if (accept) begin
        kind_q <= kind_req;
      end
    end
  end

  // Handshakes and datapath strobes
  assign s_ready = (state == ST_IDLE);
  assign load    = accept && keep_req;
  assign step    = (state == ST_PARSE);
  assign q_push  = (state == ST_SEND) || (state == ST_RAW_SEND);

  // Datapath sees the offered kind at load, the held kind afterwards
  assign kind = (state == ST_IDLE) ? kind_req : kind_q;

endmodule

`default_nettype wire

// File: hdl/rdma_opcode_pkg.sv
// RDMA opcode definitions
// Wire opcodes of the RC transport, application opcodes, request modes
// and the segment kinds used inside the segmenter

`default_nettype none

package rdma_opcode_pkg;

  ////////////////////////////////////////
  // Segment kinds
  ////////////////////////////////////////
  typedef logic [1:0] seg_kind_t;

  localparam seg_kind_t SEG_READ  = 2'd0;  // Cut at the read limit
  localparam seg_kind_t SEG_WRITE = 2'd1;  // Cut at the PMTU
  localparam seg_kind_t SEG_SEND  = 2'd2;  // PMTU cut, remote address zero
  localparam seg_kind_t SEG_RAW   = 2'd3;  // Single pass-through command

  ////////////////////////////////////////
  // RC wire opcodes
  ////////////////////////////////////////
  localparam rdma_field_pkg::opcode_t RC_SEND_FIRST        = 5'd0;
  localparam rdma_field_pkg::opcode_t RC_SEND_MIDDLE       = 5'd1;
  localparam rdma_field_pkg::opcode_t RC_SEND_LAST         = 5'd2;
  localparam rdma_field_pkg::opcode_t RC_SEND_ONLY         = 5'd4;
  localparam rdma_field_pkg::opcode_t RC_RDMA_WRITE_FIRST  = 5'd6;
  localparam rdma_field_pkg::opcode_t RC_RDMA_WRITE_MIDDLE = 5'd7;
  localparam rdma_field_pkg::opcode_t RC_RDMA_WRITE_LAST   = 5'd8;
  localparam rdma_field_pkg::opcode_t RC_RDMA_WRITE_ONLY   = 5'd10;
  localparam rdma_field_pkg::opcode_t RC_RDMA_READ_REQUEST = 5'd12;

  // Application opcodes, parse mode only
  localparam rdma_field_pkg::opcode_t APP_READ  = 5'd1;
  localparam rdma_field_pkg::opcode_t APP_WRITE = 5'd2;
  localparam rdma_field_pkg::opcode_t APP_SEND  = 5'd3;
  localparam rdma_field_pkg::opcode_t APP_IMMED = 5'd4;

  // Request modes
  localparam logic RDMA_MODE_PARSE = 1'b0;
  localparam logic RDMA_MODE_RAW   = 1'b1;

endpackage

`default_nettype wire

// File: hdl/rdma_field_pkg.sv
// RDMA request field definitions
// Widths and plain vector types of the work request and command fields

`default_nettype none

package rdma_field_pkg;

  ////////////////////////////////////////
  // Field widths
  ////////////////////////////////////////
  localparam int QPN_BITS    = 10;
  localparam int VADDR_BITS  = 48;
  localparam int LEN_BITS    = 32;
  localparam int OPCODE_BITS = 5;

  ////////////////////////////////////////
  // Field types
  ////////////////////////////////////////
  typedef logic [QPN_BITS-1:0]    qpn_t;     // Queue pair number
  typedef logic [VADDR_BITS-1:0]  vaddr_t;   // Local or remote virtual address
  typedef logic [LEN_BITS-1:0]    len_t;     // Byte length
  typedef logic [OPCODE_BITS-1:0] opcode_t;  // Wire or application opcode

  // One queued command, packed as qpn, opcode, last, lvaddr, rvaddr, len
  localparam int CMD_BITS = QPN_BITS + OPCODE_BITS + 1 + 2 * VADDR_BITS + LEN_BITS;

endpackage

`default_nettype wire
